// File: logic/pcs_defines.svh
/*
 * 64b/66b PCS build constants
 * widths, gearbox sequence limit, lock thresholds and the idle block
 */
`ifndef PCS_DEFINES_SVH
`define PCS_DEFINES_SVH

// block layout
`define PCS_DATA_W        64        // payload bits
`define PCS_HEAD_W        2         // sync header bits
`define PCS_BLOCK_W       66        // header + payload

// tx gearbox sequence, pauses on the last value
`define PCS_SEQ_MAX       32
`define PCS_SEQ_W         6

// rx block lock
`define PCS_LOCK_GOOD     32        // good headers in a row to lock
`define PCS_SLIP_WAIT     4         // words skipped after each slip
`define PCS_BER_WINDOW    64        // words per bad header window
`define PCS_BER_MAX       16        // bad headers per window to drop lock

// idle control block payload
// block type 1E in the low byte, rest zero
`define PCS_IDLE_PAYLOAD  64'h0000_0000_0000_001e

`endif

// File: logic/pcs_pkg.sv
/*
 * 64b/66b PCS types
 * payload, sync header and gearbox sequence types
 * plus the two legal sync header codes
 */
`include "pcs_defines.svh"

package pcs_pkg;

    typedef logic [`PCS_DATA_W-1:0] payload_t;   // scrambled part of a block
    typedef logic [`PCS_HEAD_W-1:0] sync_hdr_t;  // never scrambled
    typedef logic [`PCS_SEQ_W-1:0]  seq_t;       // gearbox sequence count

    // legal headers, 00 and 11 are line errors
    localparam sync_hdr_t HDR_DATA = 2'b01;  // all data block
    localparam sync_hdr_t HDR_CTRL = 2'b10;  // control block

endpackage

// File: logic/tx_seq_gearbox.sv
/*
 * tx sequence gearbox feed
 * takes user blocks under valid/ready and paces them by a free running
 * sequence count, one pause cycle per 33, idle blocks fill empty slots
 */
`include "pcs_defines.svh"

module tx_seq_gearbox import pcs_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    tx_vld_i,
    input  logic [`PCS_BLOCK_W-1:0] tx_block_i,   // {header, payload}
    output logic                    tx_rdy_o,
    output sync_hdr_t               gb_head_o,
    output payload_t                gb_data_o,
    output seq_t                    gb_seq_o,     // sequence of the word held
    output logic                    gb_vld_o
);

    localparam seq_t SEQ_MAX = seq_t'(`PCS_SEQ_MAX);

    seq_t seq_q;      // 0 .. SEQ_MAX, wraps
    logic take;       // user block accepted this cycle

    assign tx_rdy_o = (seq_q != SEQ_MAX);  // low only on the pause slot
    assign take     = tx_vld_i & tx_rdy_o;

    // sequence counter never stops
    always_ff @(posedge clk) begin
        if (rst_i) begin
            seq_q <= '0;
        end else begin
            seq_q <= (seq_q == SEQ_MAX) ? '0 : seq_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gb_vld_o <= 1'b0;
        end else begin
            gb_vld_o <= tx_rdy_o;  // every slot but the pause carries a word
        end
    end

    // word register, user block or idle filler
    always_ff @(posedge clk) begin
        gb_seq_o <= seq_q;
        if (take) begin
            gb_head_o <= tx_block_i[`PCS_BLOCK_W-1 -: `PCS_HEAD_W];
            gb_data_o <= tx_block_i[`PCS_DATA_W-1:0];
        end else begin
            gb_head_o <= HDR_CTRL;  // idle block keeps the line busy
            gb_data_o <= `PCS_IDLE_PAYLOAD;
        end
    end

    // one pause, then exactly 32 ready slots before the next one
    a_pause_period: assert property (@(posedge clk) disable iff (rst_i)
        !tx_rdy_o |=> tx_rdy_o [*32] ##1 !tx_rdy_o);

    // pause slot never hands a word on
    a_pause_no_word: assert property (@(posedge clk) disable iff (rst_i)
        !tx_rdy_o |=> !gb_vld_o);

endmodule

// File: logic/pcs_scrambler.sv
/*
 * 64b/66b self synchronous scrambler, x^58 + x^39 + 1
 * DESCRAMBLE 0 scrambles, 1 descrambles
 * header passes through, payload bit 0 goes first
 * descrambler drops its first word while the state primes
 */
`include "pcs_defines.svh"

module pcs_scrambler import pcs_pkg::*; #(
    parameter bit DESCRAMBLE = 1'b0
) (
    input  logic      clk,
    input  logic      rst_i,
    input  sync_hdr_t head_i,
    input  payload_t  data_i,
    input  logic      vld_i,
    output sync_hdr_t head_o,
    output payload_t  data_o,
    output logic      vld_o
);

    localparam int DATA_W = `PCS_DATA_W;

    logic [57:0] state_q;    // [0] newest line bit
    logic [57:0] state_nxt;
    payload_t    data_mix;   // payload after the polynomial
    logic        primed_q;   // state has seen one full word

    // 64 serial steps unrolled
    always_comb begin
        state_nxt = state_q;
        for (int i = 0; i < DATA_W; i++) begin
            data_mix[i] = data_i[i] ^ state_nxt[38] ^ state_nxt[57];  // taps 39, 58
            // scrambler feeds back its output, descrambler its input
            state_nxt   = {state_nxt[56:0], DESCRAMBLE ? data_i[i] : data_mix[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= '0;
            primed_q <= 1'b0;
            vld_o    <= 1'b0;
        end else begin
            vld_o <= vld_i & (primed_q | ~DESCRAMBLE);  // tx side never drops a word
            if (vld_i) begin
                state_q  <= state_nxt;  // only valid words move the state
                primed_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        head_o <= head_i;  // header goes out in clear
        data_o <= data_mix;
    end

endmodule

// File: logic/rx_block_aligner.sv
/*
 * rx block aligner
 * picks a 66 bit window out of the last two raw words, each slip moves
 * the block boundary one bit, modulo 66
 * header sits in window bits 65:64, bit 0 first on the line
 */
`include "pcs_defines.svh"

module rx_block_aligner import pcs_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`PCS_BLOCK_W-1:0] rx_word_i,
    input  logic                    rx_vld_i,
    input  logic                    slip_i,
    output sync_hdr_t               al_head_o,
    output payload_t                al_data_o,
    output logic                    al_vld_o
);

    localparam int BLOCK_W = `PCS_BLOCK_W;
    localparam int OFF_W   = $clog2(2 * BLOCK_W);  // base index reaches 66

    logic [BLOCK_W-1:0]   prev_q;   // last valid raw word
    logic [OFF_W-1:0]     off_q;    // slip count, 0 .. 65
    logic [OFF_W-1:0]     base;     // window start in the pair
    logic [2*BLOCK_W-1:0] pair;     // older word in the low half
    logic [BLOCK_W-1:0]   win;

    assign pair = {rx_word_i, prev_q};
    assign base = OFF_W'(BLOCK_W) - off_q;  // offset 0 takes the current word as is
    assign win  = pair[base +: BLOCK_W];    // each slip reaches one bit further back

    always_ff @(posedge clk) begin
        if (rst_i) begin
            off_q    <= '0;
            al_vld_o <= 1'b0;
        end else begin
            al_vld_o <= rx_vld_i;
            if (slip_i) begin
                off_q <= (off_q == OFF_W'(BLOCK_W - 1)) ? '0 : off_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_vld_i) begin
            prev_q    <= rx_word_i;
            al_head_o <= win[BLOCK_W-1 -: `PCS_HEAD_W];
            al_data_o <= win[`PCS_DATA_W-1:0];
        end
    end

    // lock side pulses slip, never holds it
    a_slip_pulse: assert property (@(posedge clk) disable iff (rst_i)
        slip_i |=> !slip_i);

endmodule

// File: logic/sync_header_lock.sv
/*
 * sync header lock
 * hunts for block lock by slipping on every bad header, locks after a
 * run of good ones, drops lock when one window holds too many bad headers
 */
`include "pcs_defines.svh"

module sync_header_lock import pcs_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  sync_hdr_t head_i,
    input  logic      vld_i,
    output logic      slip_o,
    output logic      locked_o
);

    localparam int LOCK_GOOD  = `PCS_LOCK_GOOD;
    localparam int SLIP_WAIT  = `PCS_SLIP_WAIT;
    localparam int BER_WINDOW = `PCS_BER_WINDOW;
    localparam int BER_MAX    = `PCS_BER_MAX;
    localparam int GOOD_W     = $clog2(LOCK_GOOD + 1);
    localparam int WIN_W      = $clog2(BER_WINDOW + 1);
    localparam int BAD_W      = $clog2(BER_MAX + 1);

    typedef enum logic [1:0] {
        ST_HUNT = 2'd0,
        ST_WAIT = 2'd1,  // let the new boundary reach the header
        ST_LOCK = 2'd2
    } lock_st_t;

    lock_st_t          state_q;
    logic [GOOD_W-1:0] good_q;    // good headers in a row
    logic [WIN_W-1:0]  win_q;     // words in window, also slip wait count
    logic [BAD_W-1:0]  bad_q;     // bad headers in window
    logic              hdr_ok;

    assign hdr_ok   = (head_i == HDR_DATA) || (head_i == HDR_CTRL);
    assign locked_o = (state_q == ST_LOCK);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_HUNT;
            good_q  <= '0;
            win_q   <= '0;
            bad_q   <= '0;
            slip_o  <= 1'b0;
        end else begin
            slip_o <= 1'b0;  // default, pulse only
            if (vld_i) begin
                case (state_q)
                    ST_HUNT: begin
                        if (!hdr_ok) begin
                            slip_o  <= 1'b1;  // try the next bit position
                            good_q  <= '0;
                            win_q   <= '0;
                            state_q <= ST_WAIT;
                        end else if (good_q == GOOD_W'(LOCK_GOOD - 1)) begin
                            win_q   <= '0;
                            bad_q   <= '0;
                            state_q <= ST_LOCK;
                        end else begin
                            good_q <= good_q + 1'b1;
                        end
                    end
                    ST_WAIT: begin
                        win_q <= win_q + 1'b1;
                        if (win_q == WIN_W'(SLIP_WAIT - 1)) begin
                            state_q <= ST_HUNT;
                        end
                    end
                    ST_LOCK: begin
                        if (!hdr_ok && bad_q == BAD_W'(BER_MAX - 1)) begin
                            good_q  <= '0;  // too many errors, hunt again
                            state_q <= ST_HUNT;
                        end else if (win_q == WIN_W'(BER_WINDOW - 1)) begin
                            win_q <= '0;  // window over, restart count
                            bad_q <= '0;
                        end else begin
                            win_q <= win_q + 1'b1;
                            bad_q <= bad_q + BAD_W'(!hdr_ok);
                        end
                    end
                    default: state_q <= ST_HUNT;
                endcase
            end
        end
    end

    // once locked the boundary stays put
    a_no_slip_locked: assert property (@(posedge clk) disable iff (rst_i)
        locked_o |=> !slip_o);

endmodule

// File: logic/pcs_64b66b_top.sv
/*
 * 64b/66b PCS, single clock
 * tx runs the gearbox feed then the scrambler
 * rx runs the block aligner and header lock into a descrambler
 * that is held in reset while unlocked
 */
`include "pcs_defines.svh"

module pcs_64b66b_top import pcs_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_i,
    // user tx
    input  logic                    tx_vld_i,
    input  logic [`PCS_BLOCK_W-1:0] tx_block_i,
    output logic                    tx_rdy_o,
    // line tx
    output sync_hdr_t               tx_head_o,
    output payload_t                tx_data_o,
    output logic                    tx_vld_o,
    // raw line rx words
    input  logic [`PCS_BLOCK_W-1:0] rx_word_i,
    input  logic                    rx_vld_i,
    // user rx
    output sync_hdr_t               rx_head_o,
    output payload_t                rx_data_o,
    output logic                    rx_vld_o,
    output logic                    rx_locked_o
);

    sync_hdr_t gb_head;
    payload_t  gb_data;
    logic      gb_vld;

    sync_hdr_t al_head;
    payload_t  al_data;
    logic      al_vld;
    logic      slip;
    logic      descr_rst;  // descrambler waits for block lock

    assign descr_rst = rst_i | ~rx_locked_o;

    tx_seq_gearbox u_tx_seq_gearbox (
        .clk        (clk),
        .rst_i      (rst_i),
        .tx_vld_i   (tx_vld_i),
        .tx_block_i (tx_block_i),
        .tx_rdy_o   (tx_rdy_o),
        .gb_head_o  (gb_head),
        .gb_data_o  (gb_data),
        .gb_seq_o   (),
        .gb_vld_o   (gb_vld)
    );

    pcs_scrambler #(.DESCRAMBLE(1'b0)) u_scrambler (
        .clk    (clk),
        .rst_i  (rst_i),
        .head_i (gb_head),
        .data_i (gb_data),
        .vld_i  (gb_vld),
        .head_o (tx_head_o),
        .data_o (tx_data_o),
        .vld_o  (tx_vld_o)
    );

    rx_block_aligner u_rx_block_aligner (
        .clk       (clk),
        .rst_i     (rst_i),
        .rx_word_i (rx_word_i),
        .rx_vld_i  (rx_vld_i),
        .slip_i    (slip),
        .al_head_o (al_head),
        .al_data_o (al_data),
        .al_vld_o  (al_vld)
    );

    sync_header_lock u_sync_header_lock (
        .clk      (clk),
        .rst_i    (rst_i),
        .head_i   (al_head),
        .vld_i    (al_vld),
        .slip_o   (slip),
        .locked_o (rx_locked_o)
    );

    pcs_scrambler #(.DESCRAMBLE(1'b1)) u_descrambler (
        .clk    (clk),
        .rst_i  (descr_rst),
        .head_i (al_head),
        .data_i (al_data),
        .vld_i  (al_vld),
        .head_o (rx_head_o),
        .data_o (rx_data_o),
        .vld_o  (rx_vld_o)
    );

endmodule

// File: testbench/pcs_tb.sv
/*
 * 64b/66b PCS testbench
 * tx output loops back to rx through a bit stream delayed by k bits
 * and can carry forced bad headers
 * concurrent assertions check pacing, latency and the rx blocks
 */
`include "pcs_defines.svh"

module pcs_tb import pcs_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BW        = `PCS_BLOCK_W;
    localparam int LOCK_WORDS = `PCS_BLOCK_W * (`PCS_LOCK_GOOD + `PCS_SLIP_WAIT + 2);

    logic            clk;
    logic            rst_i;
    logic            tx_vld_i;
    logic [BW-1:0]   tx_block_i;
    logic            tx_rdy_o;
    sync_hdr_t       tx_head_o;
    payload_t        tx_data_o;
    logic            tx_vld_o;
    logic [BW-1:0]   rx_word_i;
    logic            rx_vld_i;
    sync_hdr_t       rx_head_o;
    payload_t        rx_data_o;
    logic            rx_vld_o;
    logic            rx_locked_o;

    logic [31:0]     lfsr_q;        // stimulus source
    bit              line_q[$];     // loopback bit stream with bit 0 first
    logic [BW-1:0]   sb[$];         // blocks sent and awaiting rx
    logic [BW-1:0]   exp_blk;       // head of sb as seen at the clock edge
    logic            exp_have;
    logic            chk_en;        // compare rx against sb
    int              force_cnt;     // words still sent with header 00
    int              errors;
    int              tests;
    logic            rx_is_idle;

    pcs_64b66b_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[62:0], lfsr_q[0]};  // one step per bit
        end
    endtask

    assign rx_is_idle = (rx_head_o == HDR_CTRL) && (rx_data_o == `PCS_IDLE_PAYLOAD);

    // loopback line sampled and driven on the falling edge
    always @(negedge clk) begin : loopback
        logic [BW-1:0] blk;
        logic [BW-1:0] word;
        rx_vld_i = 1'b0;
        if (tx_vld_o) begin
            blk = {tx_head_o, tx_data_o};
            if (force_cnt > 0) begin
                blk[BW-1 -: 2] = 2'b00;  // line error on the header
                force_cnt--;
            end
            for (int i = 0; i < BW; i++) line_q.push_back(blk[i]);
            if (line_q.size() >= BW) begin
                for (int i = 0; i < BW; i++) word[i] = line_q.pop_front();
                rx_word_i = word;
                rx_vld_i  = 1'b1;
            end
        end
    end

    // scoreboard pushes on accept and pops on each checked rx word
    always @(posedge clk) begin
        if (!rst_i && chk_en) begin
            if (rx_vld_o && !rx_is_idle && sb.size() > 0) void'(sb.pop_front());
            if (tx_vld_i && tx_rdy_o) sb.push_back(tx_block_i);
        end
        exp_have <= (sb.size() > 0);
        exp_blk  <= (sb.size() > 0) ? sb[0] : '0;
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(rst_i) |-> (!tx_vld_o && !rx_vld_o && !rx_locked_o && tx_rdy_o))
        else begin
            errors++;
            $display("[FAIL] %0t ns outputs wrong right after reset", $time);
        end

    a_rdy_period: assert property (@(posedge clk) disable iff (rst_i)
        !tx_rdy_o |=> tx_rdy_o [*32] ##1 !tx_rdy_o)
        else begin
            errors++;
            $display("[FAIL] %0t ns tx_rdy_o pause not one in 33", $time);
        end

    a_tx_latency: assert property (@(posedge clk) disable iff (rst_i)
        (tx_vld_i && tx_rdy_o) |-> ##2 (tx_vld_o && tx_head_o == $past(tx_block_i[BW-1 -: 2], 2)))
        else begin
            errors++;
            $display("[FAIL] %0t ns accepted block not on tx 2 cycles later", $time);
        end

    // user header on the line only for a block taken 2 cycles before
    a_tx_once: assert property (@(posedge clk) disable iff (rst_i)
        (tx_vld_o && tx_head_o == HDR_DATA) |-> $past(tx_vld_i && tx_rdy_o, 2))
        else begin
            errors++;
            $display("[FAIL] %0t ns user block on tx without its own acceptance", $time);
        end

    a_rx_match: assert property (@(posedge clk) disable iff (rst_i)
        (rx_vld_o && chk_en && !rx_is_idle) |-> (exp_have && {rx_head_o, rx_data_o} == exp_blk))
        else begin
            errors++;
            $display("[FAIL] %0t ns rx block %h, expected %h", $time,
                     {rx_head_o, rx_data_o}, exp_blk);
        end

    // reset with a new line offset of k bits
    task automatic apply_reset(input int k);
        rst_i     = 1'b1;
        tx_vld_i  = 1'b0;
        chk_en    = 1'b0;
        force_cnt = 0;
        line_q.delete();
        sb.delete();
        for (int i = 0; i < k; i++) line_q.push_back(1'b0);
        repeat (8) @(negedge clk);
        rst_i = 1'b0;
    endtask

    task automatic send_block(input logic [BW-1:0] blk);
        int t;
        t = 0;
        @(negedge clk);
        tx_vld_i   = 1'b1;
        tx_block_i = blk;
        while (!tx_rdy_o && t < 100) begin  // held until the edge that takes it
            @(negedge clk);
            t++;
        end
        if (t >= 100) begin
            errors++;
            $display("tx_rdy_o never came back, block not accepted");
        end
    endtask

    task automatic send_random(input int n);
        logic [63:0] pl;
        for (int i = 0; i < n; i++) begin
            rand_bits(64, pl);
            send_block({HDR_DATA, pl});
        end
        @(negedge clk);
        tx_vld_i = 1'b0;
    endtask

    // bound counted in line words, one per tx word
    task automatic wait_lock(input logic want);
        int t;
        int words;
        t     = 0;
        words = 0;
        while (rx_locked_o != want && words < LOCK_WORDS && t < 2 * LOCK_WORDS) begin
            @(negedge clk);
            if (tx_vld_o) words++;
            t++;
        end
        if (rx_locked_o != want) begin
            errors++;
            $display("rx_locked_o did not go to %0b in time", want);
        end
    endtask

    // waits for lock and the priming word then streams data until sb drains
    task automatic data_run(input int n);
        int t;
        wait_lock(1'b1);
        repeat (6) @(negedge clk);
        chk_en = 1'b1;
        send_random(n);
        t = 0;
        while (sb.size() > 0 && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (sb.size() > 0) begin
            errors++;
            $display("%0d sent blocks never came out on rx", sb.size());
        end
        chk_en = 1'b0;
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %0d %s done, errors %0d", tests, name, errors);
    endtask

    initial begin : main
        logic [63:0] r;
        int          k;
        int          t;
        lfsr_q     = 32'ha231;
        errors     = 0;
        tests      = 0;
        tx_vld_i   = 1'b0;
        tx_block_i = '0;
        rx_word_i  = '0;
        rx_vld_i   = 1'b0;
        exp_have   = 1'b0;
        exp_blk    = '0;
        apply_reset(0);
        @(negedge clk);
        report("reset state");

        send_random(40);  // crosses at least one pause slot
        report("tx pacing");

        data_run(50);
        report("lock and data, k 0");

        rand_bits(7, r);
        k = 1 + int'(r % 65);
        apply_reset(k);
        data_run(50);
        report($sformatf("lock and data, k %0d", k));

        force_cnt = 40;  // 16 bad in one window whatever the phase
        wait_lock(1'b0);
        t = 0;
        while (force_cnt > 0 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (force_cnt > 0) begin
            errors++;
            $display("forced bad headers never all went out on the line");
        end
        data_run(50);
        report("lock loss and relock");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/pcs_pkg.sv
logic/tx_seq_gearbox.sv
logic/pcs_scrambler.sv
logic/rx_block_aligner.sv
logic/sync_header_lock.sv
logic/pcs_64b66b_top.sv
testbench/pcs_tb.sv

// File: run.sh
#!/bin/sh
# build the 64b/66b PCS testbench with Verilator, run it, grep the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -Ilogic -f src.f \
    --top-module pcs_tb -o pcs_sim > build.log 2>&1 &&
./obj_dir/pcs_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation ok" ||
    { echo "simulation not ok, see build.log and sim.log"; exit 1; }
